// File: sim.f
verilog/clkdiv_state_pkg.sv
verilog/clkdiv_cfg_pkg.sv
verilog/clkdiv_ratio_decode.sv
verilog/clkdiv_qdiv_counter.sv
verilog/clkdiv_phase_gen.sv
verilog/clkdiv_ctrl.sv
verilog/clkdiv_top.sv
verification/clkdiv_assertions.sv
verification/clkdiv_tb.sv

// File: verification/clkdiv_tb.sv
// testbench for the programmable clock divider
// drives ratio and direct configuration words, illegal words and
// back-pressure, then measures tick spacing and high time of div_clk

`timescale 1ns/10ps

module clkdiv_tb
   import clkdiv_state_pkg::*;
   import clkdiv_cfg_pkg::*;
();

   // expected compare values and legality of one word
   typedef struct packed {
      logic [cnt_w-1:0] term;
      logic [cnt_w-1:0] half;
      logic             legal;
   } exp_cfg_t;

   localparam int wait_limit = 100;

   logic      clk;
   logic      rst_n;
   logic      cfg_valid;
   cfg_word_u cfg_word;
   logic      cfg_ready;
   logic      cfg_err;
   logic      div_clk;
   logic      div_tick;
   logic      running;

   integer    seed;
   int        tick_count = 0;
   int        since_tick = 0;
   int        high_cnt   = 0;
   logic      chk_en     = 1'b0;
   exp_cfg_t  exp_cfg    = '0;
   cfg_word_u word_a;
   cfg_word_u word_b;
   int        stalls;

   clkdiv_top dut0 (
      .clk       (clk),
      .rst_n     (rst_n),
      .cfg_valid (cfg_valid),
      .cfg_word  (cfg_word),
      .cfg_ready (cfg_ready),
      .cfg_err   (cfg_err),
      .div_clk   (div_clk),
      .div_tick  (div_tick),
      .running   (running)
   );

   initial begin
      clk = 1'b0;
      forever begin
         #2 clk = ~clk;
      end
   end

   // ratio mode counts 0..n-1 and stays high for floor(n/2) cycles
   function automatic exp_cfg_t ref_cfg(cfg_word_u w);
      exp_cfg_t         r;
      logic [cnt_w-1:0] n;
      n = w.ratio_view.ratio;
      if (w.direct_view.direct) begin
         r.term  = w.direct_view.term;
         r.half  = w.direct_view.half;
         r.legal = (w.direct_view.half < w.direct_view.term);
      end else begin
         r.term  = n - 1;
         r.half  = (n / 2) - 1;
         r.legal = (n >= ratio_min);
      end
      return r;
   endfunction

   function automatic cfg_word_u make_ratio(int n);
      cfg_word_u w;
      w = '0;
      w.ratio_view.ratio = n;
      return w;
   endfunction

   function automatic cfg_word_u make_direct(int t, int h);
      cfg_word_u w;
      w = '0;
      w.direct_view.direct = 1'b1;
      w.direct_view.term   = t;
      w.direct_view.half   = h;
      return w;
   endfunction

   task automatic report_mismatch(string what, int got, int exp);
      $display("ERR %0t: %s is %0d, expected %0d", $time, what, got, exp);
      $display("Test failed");
      $fatal(1, "stopped at the first mismatch");
   endtask

   task automatic stop_with_reason(string reason);
      $display("at %0t the run failed because %s", $time, reason);
      $display("Test failed");
      $fatal(1, "stopped on a failed wait");
   endtask

   task automatic check_cfg_word(cfg_word_u got, cfg_word_u exp, string what);
      if (got !== exp) report_mismatch(what, got, exp);
   endtask

   task automatic check_count(logic [cnt_w-1:0] got, logic [cnt_w-1:0] exp, string what);
      if (got !== exp) report_mismatch(what, got, exp);
   endtask

   task automatic check_flag(logic got, logic exp, string what);
      if (got !== exp) report_mismatch(what, got, exp);
   endtask

   // the compare values that drive the counter, read back as a direct-view word
   task automatic compare_active(exp_cfg_t e, string what);
      check_cfg_word(make_direct(dut0.act_term, dut0.act_half),
                     make_direct(e.term, e.half), what);
   endtask

   // the checking process samples outputs at the falling edge where they are stable
   always @(negedge clk) begin
      if (div_tick) begin
         if (chk_en) begin
            if (since_tick < 1 || since_tick > (1 << cnt_w) || high_cnt < 1) begin
               stop_with_reason("the tick spacing or high time is out of range");
            end
            // a period of T+1 cycles and a high time of H+1 cycles
            check_count(cnt_w'(since_tick - 1), exp_cfg.term, "tick spacing minus one");
            check_count(cnt_w'(high_cnt - 1), exp_cfg.half, "high time minus one");
         end
         tick_count++;
         since_tick = 1;
         high_cnt   = div_clk ? 1 : 0;
      end else begin
         since_tick++;
         high_cnt += div_clk;
      end
   end

   task automatic check_idle();
      check_flag(div_clk, 1'b0, "div_clk in idle");
      check_flag(div_tick, 1'b0, "div_tick in idle");
      check_flag(cfg_err, 1'b0, "cfg_err in idle");
      check_flag(running, 1'b0, "running in idle");
      check_flag(cfg_ready, 1'b1, "cfg_ready in idle");
   endtask

   task automatic wait_ticks(int n);
      int target;
      int cycles;
      target = tick_count + n;
      cycles = 0;
      while (tick_count < target) begin
         @(posedge clk);
         #0.5;
         cycles++;
         if (cycles > wait_limit) stop_with_reason("the divider stopped producing ticks");
      end
   endtask

   // holds the word until it is taken and returns just after the transfer edge
   task automatic send_word(cfg_word_u w, output int stall_cycles);
      int cycles;
      cycles    = 0;
      cfg_word  = w;
      cfg_valid = 1'b1;
      @(negedge clk);
      while (!cfg_ready) begin
         cycles++;
         if (cycles > wait_limit) stop_with_reason("a configuration word was never accepted");
         @(negedge clk);
      end
      // a stalled source is released by the wrap, which also ticks
      if (cycles > 0) check_flag(div_tick, 1'b1, "div_tick when cfg_ready returns");
      @(posedge clk);
      #0.5;
      cfg_valid    = 1'b0;
      stall_cycles = cycles;
   endtask

   task automatic wait_ready();
      int cycles;
      cycles = 0;
      while (!cfg_ready) begin
         @(posedge clk);
         #0.5;
         cycles++;
         if (cycles > wait_limit) stop_with_reason("a pending update was never applied");
      end
      check_flag(div_tick, 1'b1, "div_tick at the update wrap");
   endtask

   task automatic start_divider(cfg_word_u w);
      int       st;
      exp_cfg_t e;
      e = ref_cfg(w);
      send_word(w, st);
      check_flag(cfg_err, ~e.legal, "cfg_err after the first word");
      check_flag(running, 1'b1, "running after the first word");
      check_flag(div_tick, 1'b0, "div_tick on the start edge");
      compare_active(e, "active setting after the first word");
      @(posedge clk);
      #0.5;
      check_flag(div_tick, 1'b1, "start tick");
      // the first period is short since the count has already left 0
      wait_ticks(2);
      exp_cfg = e;
      chk_en  = 1'b1;
   endtask

   task automatic update_running(cfg_word_u w);
      int       st;
      exp_cfg_t e;
      e = ref_cfg(w);
      send_word(w, st);
      check_flag(cfg_err, ~e.legal, "cfg_err after a legal word");
      check_flag(cfg_ready, 1'b0, "cfg_ready while the update is pending");
      wait_ready();
      compare_active(e, "active setting after the wrap");
      // the tick at the wrap still closes a period at the old ratio
      wait_ticks(1);
      exp_cfg = e;
      wait_ticks(3);
   endtask

   task automatic send_illegal(cfg_word_u w);
      int       st;
      exp_cfg_t e;
      e = ref_cfg(w);
      send_word(w, st);
      check_flag(cfg_err, ~e.legal, "cfg_err after an illegal word");
      check_flag(cfg_ready, 1'b1, "cfg_ready after an illegal word");
      @(posedge clk);
      #0.5;
      check_flag(cfg_err, 1'b0, "cfg_err one cycle later");
      wait_ticks(2);
   endtask

   initial begin
      seed      = 32'h5852d6d9;
      rst_n     = 1'b0;
      cfg_valid = 1'b0;
      cfg_word  = '0;
      repeat (10) begin
         @(posedge clk);
         #0.5;
         check_idle();
      end
      rst_n = 1'b1;
      repeat (6) begin
         @(posedge clk);
         #0.5;
         check_idle();
      end

      start_divider(make_ratio(2 + ($unsigned($random(seed)) % 14)));
      wait_ticks(3);

      repeat (6) begin
         update_running(make_ratio(2 + ($unsigned($random(seed)) % 14)));
      end

      repeat (6) begin
         int t;
         t = 1 + ($unsigned($random(seed)) % 15);
         update_running(make_direct(t, $unsigned($random(seed)) % t));
      end

      // illegal words leave the active setting alone
      send_illegal(make_ratio(0));
      send_illegal(make_ratio(1));
      send_illegal(make_direct(5, 5));
      send_illegal(make_direct(3, 9));

      // second word arrives while the first one is still pending
      word_a = make_ratio(2 + ($unsigned($random(seed)) % 14));
      word_b = make_ratio(2 + ($unsigned($random(seed)) % 14));
      send_word(word_a, stalls);
      check_flag(cfg_ready, 1'b0, "cfg_ready with the first word pending");
      send_word(word_b, stalls);
      check_flag(stalls > 0, 1'b1, "second word stalled");
      exp_cfg = ref_cfg(word_a);
      compare_active(exp_cfg, "first word applied at the wrap");
      wait_ready();
      compare_active(ref_cfg(word_b), "second word applied at the wrap");
      wait_ticks(1);
      exp_cfg = ref_cfg(word_b);
      wait_ticks(3);

      if (dut0.u_ctrl.u_assert.fail_count == 0) begin
         $display("Test completed successfully");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

// File: verification/clkdiv_assertions.sv
// protocol assertions for the clock divider update control
// bound into the control block, they watch the error pulse, the
// handshake while an update waits, and the running flag

`timescale 1ns/10ps

module clkdiv_assertions
   import clkdiv_state_pkg::*;
(
   input logic        clk,
   input logic        rst_n,
   input ctrl_state_e state,
   input logic        full_cmp,
   input logic        cfg_ready,
   input logic        cfg_err,
   input logic        running
);

   // number of assertion failures over the whole run
   int fail_count = 0;

   // an illegal word is flagged for one cycle only
   property p_err_single;
      @(posedge clk) disable iff (!rst_n)
         cfg_err |=> !cfg_err;
   endproperty

   // a held update stalls the source until the counter wraps
   property p_ready_in_pend;
      @(posedge clk) disable iff (!rst_n)
         ((state == st_pend) && !full_cmp) |=> !cfg_ready;
   endproperty

   // once a setting is active the divider never returns to idle
   property p_running_holds;
      @(posedge clk) disable iff (!rst_n)
         running |=> running;
   endproperty

   a_err_single: assert property (p_err_single)
      else begin
         fail_count++;
         $error("cfg_err stayed high for more than one cycle");
      end

   a_ready_in_pend: assert property (p_ready_in_pend)
      else begin
         fail_count++;
         $error("cfg_ready high while an update is pending");
      end

   a_running_holds: assert property (p_running_holds)
      else begin
         fail_count++;
         $error("running fell after it had risen");
      end

endmodule

bind clkdiv_ctrl clkdiv_assertions u_assert (
   .clk       (clk),
   .rst_n     (rst_n),
   .state     (state),
   .full_cmp  (full_cmp),
   .cfg_ready (cfg_ready),
   .cfg_err   (cfg_err),
   .running   (running)
);

// File: verilog/clkdiv_top.sv
// programmable integer clock divider
// a configuration word is decoded into compare values, the control
// block applies them at counter wraps, and the phase generator turns
// the compare events into the divided clock and its period tick

`timescale 1ns/10ps

module clkdiv_top
   import clkdiv_state_pkg::*;
   import clkdiv_cfg_pkg::*;
(
   input  logic      clk,
   input  logic      rst_n,
   input  logic      cfg_valid,
   input  cfg_word_u cfg_word,
   output logic      cfg_ready,
   output logic      cfg_err,
   output logic      div_clk,
   output logic      div_tick,
   output logic      running
);

   logic [cnt_w-1:0] dec_term;
   logic [cnt_w-1:0] dec_half;
   logic             dec_legal;
   logic [cnt_w-1:0] act_term;
   logic [cnt_w-1:0] act_half;
   logic             ctrl_restart;
   logic             div_en;
   logic             full_cmp;
   logic             half_cmp;

   // the phase generator runs whenever the counter is released
   assign div_en = ~ctrl_restart;

   clkdiv_ratio_decode u_decode (
      .cfg_word  (cfg_word),
      .term_val  (dec_term),
      .half_val  (dec_half),
      .cfg_legal (dec_legal)
   );

   clkdiv_ctrl u_ctrl (
      .clk       (clk),
      .rst_n     (rst_n),
      .cfg_valid (cfg_valid),
      .cfg_ready (cfg_ready),
      .term_val  (dec_term),
      .half_val  (dec_half),
      .cfg_legal (dec_legal),
      .full_cmp  (full_cmp),
      .cfg_err   (cfg_err),
      .act_term  (act_term),
      .act_half  (act_half),
      .restart   (ctrl_restart),
      .running   (running)
   );

   // the raw count stays internal, only the compare flags leave the counter
   clkdiv_qdiv_counter u_counter (
      .clk      (clk),
      .rst_n    (rst_n),
      .restart  (ctrl_restart),
      .term_val (act_term),
      .half_val (act_half),
      .count    (),
      .full_cmp (full_cmp),
      .half_cmp (half_cmp)
   );

   clkdiv_phase_gen u_phase (
      .clk      (clk),
      .rst_n    (rst_n),
      .enable   (div_en),
      .full_cmp (full_cmp),
      .half_cmp (half_cmp),
      .div_clk  (div_clk),
      .div_tick (div_tick)
   );

endmodule

// File: verilog/clkdiv_ctrl.sv
// clock divider update control
// accepts configuration words over a valid/ready handshake, reports
// illegal ones, and moves new compare values in only at a counter wrap
// so the divided clock never sees a shortened phase

`timescale 1ns/10ps

module clkdiv_ctrl
   import clkdiv_state_pkg::*;
(
   input  logic               clk,
   input  logic               rst_n,
   input  logic               cfg_valid,
   output logic               cfg_ready,
   input  logic [cnt_w-1:0]   term_val,
   input  logic [cnt_w-1:0]   half_val,
   input  logic               cfg_legal,
   input  logic               full_cmp,
   output logic               cfg_err,
   output logic [cnt_w-1:0]   act_term,
   output logic [cnt_w-1:0]   act_half,
   output logic               restart,
   output logic               running
);

   ctrl_state_e      state;
   ctrl_state_e      state_nxt;
   logic [cnt_w-1:0] pend_term;
   logic [cnt_w-1:0] pend_half;
   logic             xfer;
   logic             take_legal;
   logic             load_idle;
   logic             load_pend;
   logic             apply_pend;

   // only one update can wait at a time, so the source is stalled in pend
   assign cfg_ready = (state != st_pend);
   assign xfer      = cfg_valid & cfg_ready;
   assign take_legal = xfer & cfg_legal;

   // the first word goes straight in, later ones wait for the wrap
   assign load_idle  = (state == st_idle) & take_legal;
   assign load_pend  = (state == st_run) & take_legal;
   assign apply_pend = (state == st_pend) & full_cmp;

   // the counter and phase generator idle until a first setting exists
   assign restart = (state == st_idle);
   assign running = (state != st_idle);

   always_comb begin
      state_nxt = state;
      case (state)
         st_idle: begin
            if (take_legal) begin
               state_nxt = st_run;
            end
         end
         st_run: begin
            if (take_legal) begin
               state_nxt = st_pend;
            end
         end
         st_pend: begin
            // the wrap clears the count on this same edge
            if (full_cmp) begin
               state_nxt = st_run;
            end
         end
         default: begin
            state_nxt = st_idle;
         end
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state <= st_idle;
      end else begin
         state <= state_nxt;
      end
   end

   // active compare values seen by the counter
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         act_term <= '0;
         act_half <= '0;
      end else if (load_idle) begin
         act_term <= term_val;
         act_half <= half_val;
      end else if (apply_pend) begin
         act_term <= pend_term;
         act_half <= pend_half;
      end
   end

   // waiting update captured from a legal word taken while running
   always_ff @(posedge clk) begin
      if (load_pend) begin
         pend_term <= term_val;
         pend_half <= half_val;
      end
   end

   // an illegal word is consumed and reported for one cycle while nothing else moves
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         cfg_err <= 1'b0;
      end else begin
         cfg_err <= xfer & ~cfg_legal;
      end
   end

endmodule

// File: verilog/clkdiv_phase_gen.sv
// clock divider phase generator
// builds the divided clock level and the once-per-period tick from the
// counter compare events, with a start tick when the divider is enabled

`timescale 1ns/10ps

module clkdiv_phase_gen (
   input  logic clk,
   input  logic rst_n,
   input  logic enable,
   input  logic full_cmp,
   input  logic half_cmp,
   output logic div_clk,
   output logic div_tick
);

   logic en_q;
   logic start;

   // first cycle of a run, treated like a wrap so the output starts high
   assign start = enable & ~en_q;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         en_q <= 1'b0;
      end else begin
         en_q <= enable;
      end
   end

   // registered wrap tick, the counter sits at 0 with a stale terminal in idle
   // so the enable gate keeps the tick quiet there
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         div_tick <= 1'b0;
      end else begin
         div_tick <= enable & (full_cmp | start);
      end
   end

   // rise one cycle after the wrap, fall one cycle after the half point
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         div_clk <= 1'b0;
      end else if (!enable) begin
         div_clk <= 1'b0;
      end else if (full_cmp | start) begin
         div_clk <= 1'b1;
      end else if (half_cmp) begin
         div_clk <= 1'b0;
      end
   end

endmodule

// File: verilog/clkdiv_qdiv_counter.sv
// clock divider terminal counter
// ripple-enable binary counter with per-bit compare cells that report
// when the count reaches the terminal and the half points

`timescale 1ns/10ps

module clkdiv_qdiv_counter
   import clkdiv_state_pkg::*;
(
   input  logic               clk,
   input  logic               rst_n,
   input  logic               restart,
   input  logic [cnt_w-1:0]   term_val,
   input  logic [cnt_w-1:0]   half_val,
   output logic [cnt_w-1:0]   count,
   output logic               full_cmp,
   output logic               half_cmp
);

   logic [cnt_w-1:0] den;
   logic [cnt_w-1:0] full_match;
   logic [cnt_w-1:0] half_match;
   logic             clr;

   // a wrap and a control restart both send the count back to 0
   assign clr = restart | full_cmp;

   // bit 0 toggles every cycle
   assign den[0] = 1'b1;

   genvar i;
   generate
      for (i = 1; i < cnt_w; i++) begin : g_den
         // bit i may toggle only when every lower bit is one
         assign den[i] = den[i-1] & count[i-1];
      end

      for (i = 0; i < cnt_w; i++) begin : g_bit
         // one toggle cell per bit with a synchronous clear
         always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
               count[i] <= 1'b0;
            end else if (clr) begin
               count[i] <= 1'b0;
            end else if (den[i]) begin
               count[i] <= ~count[i];
            end
         end

         // local compare of this bit against both targets
         assign full_match[i] = ~(count[i] ^ term_val[i]);
         assign half_match[i] = ~(count[i] ^ half_val[i]);
      end
   endgenerate

   // all bits must agree for a compare hit
   assign full_cmp = &full_match;
   assign half_cmp = &half_match;

endmodule

// File: verilog/clkdiv_ratio_decode.sv
// clock divider configuration decoder
// turns a configuration word into terminal and half compare values
// and flags whether the word describes a usable divide setting

`timescale 1ns/10ps

module clkdiv_ratio_decode
   import clkdiv_state_pkg::*;
   import clkdiv_cfg_pkg::*;
(
   input  cfg_word_u          cfg_word,
   output logic [cnt_w-1:0]   term_val,
   output logic [cnt_w-1:0]   half_val,
   output logic               cfg_legal
);

   logic [cnt_w-1:0] ratio_n;
   logic [cnt_w-1:0] half_ratio;

   // ratio view of the word, only meaningful when the direct bit is low
   assign ratio_n    = cfg_word.ratio_view.ratio;
   assign half_ratio = ratio_n >> 1;

   always_comb begin
      if (cfg_word.direct_view.direct) begin
         // raw compare values are passed through untouched
         term_val  = cfg_word.direct_view.term;
         half_val  = cfg_word.direct_view.half;
         // the fall point has to come before the wrap or the clock never goes low
         cfg_legal = (cfg_word.direct_view.half < cfg_word.direct_view.term);
      end else begin
         // counting 0..n-1 gives a period of n cycles
         term_val  = ratio_n - 1'b1;
         // high for floor(n/2) cycles, odd ratios put the extra cycle low
         half_val  = half_ratio - 1'b1;
         // n of 0 or 1 would wrap the subtractions above
         cfg_legal = (ratio_n >= cnt_w'(ratio_min));
      end
   end

endmodule

// File: verilog/clkdiv_cfg_pkg.sv
// clock divider configuration word definitions
// one word carries either a divide ratio or raw compare values,
// selected by its top bit, plus the ratio limits used by the decoder

package clkdiv_cfg_pkg;

   import clkdiv_state_pkg::*;

   // direct bit plus two compare-sized fields
   localparam int unsigned cfg_w = 1 + 2 * cnt_w;

   // a ratio below this cannot form a high and a low phase
   localparam int unsigned ratio_min = 2;

   // the same 9 bits read two ways, the direct bit sits on top in both
   typedef union packed {
      // ratio mode, the compare points are derived from n
      struct packed {
         logic                     direct;
         logic [cfg_w-cnt_w-2:0]   spare;
         logic [cnt_w-1:0]         ratio;
      } ratio_view;
      // direct mode, terminal and half are used as given
      struct packed {
         logic                     direct;
         logic [cnt_w-1:0]         term;
         logic [cnt_w-1:0]         half;
      } direct_view;
   } cfg_word_u;

endpackage

// File: verilog/clkdiv_state_pkg.sv
// clock divider counter and control state definitions
// holds the counter width shared by the datapath and the encoding
// of the control FSM that sequences divide updates

package clkdiv_state_pkg;

   // width of the terminal counter and of every compare value
   localparam int unsigned cnt_w = 4;

   // control FSM states
   // idle keeps the counter in restart until a first legal word arrives
   // run divides with the active values and takes one new word
   // pend holds that word until the counter wraps
   typedef enum logic [1:0] {
      st_idle = 2'b00,
      st_run  = 2'b01,
      st_pend = 2'b10
   } ctrl_state_e;

endpackage
